// ==== logic/aes_ctrl_params.svh ====
// Constants for the sparse code, round counter and round counts, included by package and RTL
`ifndef AES_CTRL_PARAMS_SVH
`define AES_CTRL_PARAMS_SVH

// Sparse two-value code, one rail per bit
`define AES_SP2V_WIDTH 3
`define AES_SP2V_HIGH  3'b011
`define AES_SP2V_LOW   3'b100

// Round counter
`define AES_RND_CTR_W  4

// Rounds per key length
`define AES_NR_128     10
`define AES_NR_192     12
`define AES_NR_256     14

`endif

// ==== logic/aes_ctrl_pkg.sv ====
// Sparse enums and packed structs shared by the round controller RTL and its testbench
`include "aes_ctrl_params.svh"

package aes_ctrl_pkg;

  // Sparse two-value signal, any other code is illegal
  typedef enum logic [`AES_SP2V_WIDTH-1:0] {
    SP2V_HIGH = `AES_SP2V_HIGH,
    SP2V_LOW  = `AES_SP2V_LOW
  } sp2v_e;

  // One-hot key length
  typedef enum logic [2:0] {
    KEY_128 = 3'b001,
    KEY_192 = 3'b010,
    KEY_256 = 3'b100
  } key_len_e;

  typedef enum logic [2:0] {
    STATE_INIT  = 3'b011,
    STATE_ROUND = 3'b101,
    STATE_CLEAR = 3'b110
  } state_sel_e;

  typedef enum logic [2:0] {
    ADD_RK_INIT  = 3'b001,
    ADD_RK_ROUND = 3'b010,
    ADD_RK_FINAL = 3'b100
  } add_rk_sel_e;

  // Selector payload of one rail
  typedef struct packed {
    state_sel_e  state_sel;
    add_rk_sel_e add_rk_sel;
  } sel_bundle_t;

  // Datapath control towards the cipher state and key adder
  typedef struct packed {
    state_sel_e                state_sel;
    sp2v_e                     state_we;
    add_rk_sel_e               add_rk_sel;
    logic [`AES_RND_CTR_W-1:0] round;
  } dp_ctrl_t;

  typedef logic [`AES_SP2V_WIDTH-1:0] rail_bits_t; // One bit per rail

endpackage

// ==== logic/aes_sparse_chk.sv ====
// Splits sparse two-value inputs into rail bits and flags illegal codes for the controller top
`timescale 1ns/1ps
`include "aes_ctrl_params.svh"

module aes_sparse_chk #(
  parameter int unsigned NumSig = 2
) (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  aes_ctrl_pkg::sp2v_e      [NumSig-1:0]  sig_i,
  output aes_ctrl_pkg::rail_bits_t [NumSig-1:0]  bits_o,
  output logic                                   err_o
);
  import aes_ctrl_pkg::*;

  always_comb begin
    err_o = 1'b0;
    for (int i = 0; i < NumSig; i++) begin
      bits_o[i] = rail_bits_t'(sig_i[i]); // Raw bits, one per rail
      err_o     = err_o | (sig_i[i] != SP2V_HIGH && sig_i[i] != SP2V_LOW); // Unknown code gives X
    end
  end

  // Error flag must stay resolved so the rails never see X
  a_err_known : assert property (
    @(posedge clk_i) disable iff (!rst_ni) !$isunknown(err_o)
  );

endmodule

// ==== logic/aes_round_fsm.sv ====
// Single rail of the redundant AES round controller, instantiated once per bit of the sparse code
`timescale 1ns/1ps
`include "aes_ctrl_params.svh"

module aes_round_fsm #(
  parameter bit ActiveHigh = 1'b1
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,

  // Handshakes, one bit of each sparse signal in this rail's polarity
  input  logic                        in_valid_i,
  output logic                        in_ready_o,
  output logic                        out_valid_o,
  input  logic                        out_ready_i,

  input  aes_ctrl_pkg::key_len_e      key_len_i,
  input  logic                        enc_err_i,
  input  logic                        sel_err_i,
  input  logic                        ctr_err_i,
  output logic                        alert_o,

  output logic                        state_we_o,
  output aes_ctrl_pkg::sel_bundle_t   sel_o,
  output logic [`AES_RND_CTR_W-1:0]   rnd_o
);
  import aes_ctrl_pkg::*;

  // Encodings kept apart so a single flipped bit lands in default
  typedef enum logic [4:0] {
    IDLE   = 5'b01110,
    INIT   = 5'b11011,
    ROUND  = 5'b00101,
    FINISH = 5'b10000,
    ERROR  = 5'b11101
  } fsm_e;

  fsm_e                      state_d, state_q;
  logic [`AES_RND_CTR_W-1:0] rnd_d, rnd_q;
  logic [`AES_RND_CTR_W-1:0] nr_d, nr_q;   // Last round, latched at start
  logic                      in_valid, out_ready;
  logic                      in_ready, out_valid, state_we;

  // Rail polarity
  assign in_valid    = ActiveHigh ? in_valid_i  : ~in_valid_i;
  assign out_ready   = ActiveHigh ? out_ready_i : ~out_ready_i;
  assign in_ready_o  = ActiveHigh ? in_ready    : ~in_ready;
  assign out_valid_o = ActiveHigh ? out_valid   : ~out_valid;
  assign state_we_o  = ActiveHigh ? state_we    : ~state_we;

  ////////////////////////////////////////////////////////////////////////////
  // Next state
  always_comb begin
    state_d = state_q;
    rnd_d   = rnd_q;
    nr_d    = nr_q;
    case (state_q)
      IDLE: begin
        if (in_valid) begin // Ready is implied in idle
          state_d = INIT;
          case (key_len_i)
            KEY_128: nr_d = `AES_RND_CTR_W'(`AES_NR_128);
            KEY_192: nr_d = `AES_RND_CTR_W'(`AES_NR_192);
            KEY_256: nr_d = `AES_RND_CTR_W'(`AES_NR_256);
            default: state_d = ERROR;
          endcase
        end
      end
      INIT: begin
        state_d = ROUND;
        rnd_d   = `AES_RND_CTR_W'(1);
      end
      ROUND: begin
        if (rnd_q == nr_q) begin
          state_d = FINISH;
          rnd_d   = '0;
        end else begin
          rnd_d = rnd_q + 1'b1;
        end
      end
      FINISH: if (out_ready) state_d = IDLE;
      ERROR:  state_d = ERROR; // Terminal
      default: state_d = ERROR;
    endcase

    // Any detected fault overrides the sequence
    if (enc_err_i || sel_err_i || ctr_err_i) begin
      state_d = ERROR;
      rnd_d   = '0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Outputs, from state only
  always_comb begin
    in_ready         = 1'b0;
    out_valid        = 1'b0;
    state_we         = 1'b0;
    alert_o          = 1'b0;
    sel_o.state_sel  = STATE_CLEAR;
    sel_o.add_rk_sel = ADD_RK_INIT;
    case (state_q)
      IDLE: in_ready = 1'b1;
      INIT: begin
        state_we        = 1'b1;
        sel_o.state_sel = STATE_INIT;
      end
      ROUND: begin
        state_we         = 1'b1;
        sel_o.state_sel  = STATE_ROUND;
        sel_o.add_rk_sel = (rnd_q == nr_q) ? ADD_RK_FINAL : ADD_RK_ROUND;
      end
      FINISH:  out_valid = 1'b1;
      default: alert_o   = 1'b1; // Error and illegal states
    endcase
  end

  assign rnd_o = rnd_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      rnd_q   <= '0;
      nr_q    <= `AES_RND_CTR_W'(`AES_NR_128);
    end else begin
      state_q <= state_d;
      rnd_q   <= rnd_d;
      nr_q    <= nr_d;
    end
  end

  // Only reset leaves the error state
  a_error_sticky : assert property (
    @(posedge clk_i) disable iff (!rst_ni) state_q == ERROR |=> state_q == ERROR
  );

endmodule

// ==== logic/aes_rail_combine.sv ====
// OR-combines one payload from all controller rails and flags any rail that disagrees
`timescale 1ns/1ps
`include "aes_ctrl_params.svh"

module aes_rail_combine #(
  parameter type payload_t = logic [`AES_RND_CTR_W-1:0]
) (
  input  payload_t [`AES_SP2V_WIDTH-1:0] rail_i,
  output payload_t                       comb_o,
  output logic                           err_o
);

  // A single rail can raise a bit
  always_comb begin
    comb_o = '0;
    for (int i = 0; i < `AES_SP2V_WIDTH; i++) begin
      comb_o = payload_t'(comb_o | rail_i[i]);
    end
  end

  // Any rail short of the combined value is out of step
  always_comb begin
    err_o = 1'b0;
    for (int i = 0; i < `AES_SP2V_WIDTH; i++) begin
      if (rail_i[i] != comb_o) begin
        err_o = 1'b1;
      end
    end
  end

endmodule

// ==== logic/aes_ctrl_out.sv ====
// Output stage of the round controller, rebuilds sparse signals and merges the alert rails
`timescale 1ns/1ps
`include "aes_ctrl_params.svh"

module aes_ctrl_out (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  aes_ctrl_pkg::rail_bits_t    in_ready_i,
  input  aes_ctrl_pkg::rail_bits_t    out_valid_i,
  input  aes_ctrl_pkg::rail_bits_t    state_we_i,
  input  aes_ctrl_pkg::rail_bits_t    alert_i,
  input  aes_ctrl_pkg::sel_bundle_t   sel_i,
  input  logic [`AES_RND_CTR_W-1:0]   rnd_i,
  output aes_ctrl_pkg::sp2v_e         in_ready_o,
  output aes_ctrl_pkg::sp2v_e         out_valid_o,
  output aes_ctrl_pkg::dp_ctrl_t      dp_ctrl_o,
  output logic                        alert_o
);
  import aes_ctrl_pkg::*;

  assign alert_o    = |alert_i;
  assign in_ready_o = sp2v_e'(in_ready_i);

  // No result leaves once a fault is seen
  assign out_valid_o = alert_o ? SP2V_LOW : sp2v_e'(out_valid_i);

  assign dp_ctrl_o.state_sel  = sel_i.state_sel;
  assign dp_ctrl_o.state_we   = sp2v_e'(state_we_i);
  assign dp_ctrl_o.add_rk_sel = sel_i.add_rk_sel;
  assign dp_ctrl_o.round      = rnd_i;

  // Alert stays up and keeps the output closed
  a_alert_blocks_valid : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    alert_o |=> alert_o && out_valid_o != SP2V_HIGH
  );

endmodule

// ==== logic/aes_round_ctrl.sv ====
// Top of the redundant AES round controller, one FSM rail per bit of the sparse handshake code
`timescale 1ns/1ps
`include "aes_ctrl_params.svh"

module aes_round_ctrl (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  aes_ctrl_pkg::sp2v_e      in_valid_i,
  output aes_ctrl_pkg::sp2v_e      in_ready_o,
  input  aes_ctrl_pkg::key_len_e   key_len_i,
  output aes_ctrl_pkg::sp2v_e      out_valid_o,
  input  aes_ctrl_pkg::sp2v_e      out_ready_i,
  output aes_ctrl_pkg::dp_ctrl_t   dp_ctrl_o,
  output logic                     alert_o
);
  import aes_ctrl_pkg::*;

  localparam rail_bits_t RailPolarity = SP2V_HIGH; // Bit i set means rail i is active high

  sp2v_e       [1:0]                                   chk_sig;
  rail_bits_t  [1:0]                                   chk_bits;
  logic                                                enc_err;
  rail_bits_t                                          rail_in_ready;
  rail_bits_t                                          rail_out_valid;
  rail_bits_t                                          rail_state_we;
  rail_bits_t                                          rail_alert;
  sel_bundle_t [`AES_SP2V_WIDTH-1:0]                   rail_sel;
  logic        [`AES_SP2V_WIDTH-1:0][`AES_RND_CTR_W-1:0] rail_rnd;
  sel_bundle_t                                         sel;
  logic        [`AES_RND_CTR_W-1:0]                    rnd;
  logic                                                sel_err;
  logic                                                ctr_err;

  ////////////////////////////////////////////////////////////////////////////
  // Input code check
  assign chk_sig[0] = in_valid_i;
  assign chk_sig[1] = out_ready_i;

  aes_sparse_chk #(
    .NumSig ( 2 )
  ) u_sparse_chk (
    .clk_i  ( clk_i    ),
    .rst_ni ( rst_ni   ),
    .sig_i  ( chk_sig  ),
    .bits_o ( chk_bits ),
    .err_o  ( enc_err  )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Rails
  for (genvar i = 0; i < `AES_SP2V_WIDTH; i++) begin : gen_rail
    aes_round_fsm #(
      .ActiveHigh ( RailPolarity[i] )
    ) u_round_fsm (
      .clk_i       ( clk_i             ),
      .rst_ni      ( rst_ni            ),
      .in_valid_i  ( chk_bits[0][i]    ),
      .in_ready_o  ( rail_in_ready[i]  ),
      .out_valid_o ( rail_out_valid[i] ),
      .out_ready_i ( chk_bits[1][i]    ),
      .key_len_i   ( key_len_i         ),
      .enc_err_i   ( enc_err           ),
      .sel_err_i   ( sel_err           ),
      .ctr_err_i   ( ctr_err           ),
      .alert_o     ( rail_alert[i]     ), // OR-combined
      .state_we_o  ( rail_state_we[i]  ),
      .sel_o       ( rail_sel[i]       ),
      .rnd_o       ( rail_rnd[i]       )
    );
  end

  // Selectors and round count, compared across rails
  aes_rail_combine #(
    .payload_t ( sel_bundle_t )
  ) u_sel_combine (
    .rail_i ( rail_sel ),
    .comb_o ( sel      ),
    .err_o  ( sel_err  )
  );

  aes_rail_combine #(
    .payload_t ( logic [`AES_RND_CTR_W-1:0] )
  ) u_rnd_combine (
    .rail_i ( rail_rnd ),
    .comb_o ( rnd      ),
    .err_o  ( ctr_err  )
  );

  aes_ctrl_out u_ctrl_out (
    .clk_i       ( clk_i          ),
    .rst_ni      ( rst_ni         ),
    .in_ready_i  ( rail_in_ready  ),
    .out_valid_i ( rail_out_valid ),
    .state_we_i  ( rail_state_we  ),
    .alert_i     ( rail_alert     ),
    .sel_i       ( sel            ),
    .rnd_i       ( rnd            ),
    .in_ready_o  ( in_ready_o     ),
    .out_valid_o ( out_valid_o    ),
    .dp_ctrl_o   ( dp_ctrl_o      ),
    .alert_o     ( alert_o        )
  );

endmodule

// ==== sim/tb_aes_round_ctrl.sv ====
// Testbench for the redundant AES round controller, compiled from list.f as the simulation top
`timescale 1ns/1ps
`include "aes_ctrl_params.svh"

module tb_aes_round_ctrl;
  import aes_ctrl_pkg::*;

  localparam int ClkPeriod   = 20;
  localparam int IdxIdle     = -1;
  localparam int IdxError    = -2;
  localparam int BlockCyc    = `AES_NR_256 + 12; // Rounds, init, finish, stall, slack
  localparam int NumBlocks   = 24;
  localparam int ResetCyc    = 12;
  localparam int WatchdogCyc = NumBlocks * BlockCyc + 6 * ResetCyc + 40 + 200;

  // Expected outputs for one clock cycle
  typedef struct packed {
    dp_ctrl_t ctrl;
    sp2v_e    in_ready;
    sp2v_e    out_valid;
    logic     alert;
  } exp_t;

  logic     clk_i = 1'b0;
  logic     rst_ni;
  sp2v_e    in_valid;
  sp2v_e    in_ready;
  key_len_e key_len;
  sp2v_e    out_valid;
  sp2v_e    out_ready;
  dp_ctrl_t dp_ctrl;
  logic     alert;

  exp_t exp_q;
  bit   chk_en       = 1'b0;
  int   err_cnt      = 0;
  int   chk_cnt      = 0;
  int   tests_run    = 0;
  int   tests_failed = 0;
  int   test_base    = 0;

  aes_round_ctrl aes_round_ctrl_i (
    .clk_i       ( clk_i     ),
    .rst_ni      ( rst_ni    ),
    .in_valid_i  ( in_valid  ),
    .in_ready_o  ( in_ready  ),
    .key_len_i   ( key_len   ),
    .out_valid_o ( out_valid ),
    .out_ready_i ( out_ready ),
    .dp_ctrl_o   ( dp_ctrl   ),
    .alert_o     ( alert     )
  );

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  function automatic int num_rounds(input key_len_e kl);
    case (kl)
      KEY_192: return `AES_NR_192;
      KEY_256: return `AES_NR_256;
      default: return `AES_NR_128;
    endcase
  endfunction

  // Index 0 is the initial cycle, 1 to Nr the rounds, beyond that the result
  function automatic exp_t exp_ctrl(input key_len_e kl, input int idx);
    exp_t e;
    int   nr;
    nr                 = num_rounds(kl);
    e.alert            = 1'b0;
    e.in_ready         = SP2V_LOW;
    e.out_valid        = SP2V_LOW;
    e.ctrl.state_sel   = STATE_CLEAR;
    e.ctrl.state_we    = SP2V_LOW;
    e.ctrl.add_rk_sel  = ADD_RK_INIT;
    e.ctrl.round       = '0;
    if (idx == IdxIdle) begin
      e.in_ready = SP2V_HIGH;
    end else if (idx == IdxError) begin
      e.alert = 1'b1; // Datapath control is don't-care here
    end else if (idx == 0) begin
      e.ctrl.state_sel = STATE_INIT;
      e.ctrl.state_we  = SP2V_HIGH;
    end else if (idx <= nr) begin
      e.ctrl.state_sel  = STATE_ROUND;
      e.ctrl.state_we   = SP2V_HIGH;
      e.ctrl.add_rk_sel = (idx == nr) ? ADD_RK_FINAL : ADD_RK_ROUND;
      e.ctrl.round      = `AES_RND_CTR_W'(idx);
    end else begin
      e.out_valid = SP2V_HIGH; // Held until taken
    end
    return e;
  endfunction

  function automatic key_len_e rand_key();
    case ($urandom % 3)
      0:       return KEY_128;
      1:       return KEY_192;
      default: return KEY_256;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Comparator, mid-cycle when all outputs are settled
  task automatic report_mismatch(input string what, input logic [15:0] got,
                                 input logic [15:0] want);
    err_cnt++;
    $display("FAIL %0d ns: %s is %h, expected %h", $time, what, got, want);
  endtask

  always @(negedge clk_i) begin
    if (chk_en) begin
      chk_cnt++;
      if (alert !== exp_q.alert) begin
        report_mismatch("alert_o", 16'(alert), 16'(exp_q.alert));
      end
      if (in_ready !== exp_q.in_ready) begin
        report_mismatch("in_ready_o", 16'(in_ready), 16'(exp_q.in_ready));
      end
      if (out_valid !== exp_q.out_valid) begin
        report_mismatch("out_valid_o", 16'(out_valid), 16'(exp_q.out_valid));
      end
      if (!exp_q.alert && dp_ctrl !== exp_q.ctrl) begin
        report_mismatch("dp_ctrl_o", dp_ctrl, exp_q.ctrl);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  task automatic next_cycle();
    @(posedge clk_i);
    #2;
  endtask

  task automatic apply_reset();
    chk_en    = 1'b0;
    rst_ni    = 1'b0;
    in_valid  = SP2V_LOW;
    out_ready = SP2V_LOW;
    key_len   = KEY_128;
    repeat (8) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    exp_q  = exp_ctrl(KEY_128, IdxIdle);
    chk_en = 1'b1;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (err_cnt == test_base) begin
      $display("Test %s: passed", name);
    end else begin
      tests_failed++;
      $display("Test %s: failed with %0d errors", name, err_cnt - test_base);
    end
    test_base = err_cnt;
  endtask

  // One block from idle, stall cycles of back-pressure before the result is taken
  task automatic run_block(input key_len_e kl, input int stall);
    int idx;
    int nr;
    nr       = num_rounds(kl);
    idx      = 0;
    in_valid = SP2V_HIGH;
    key_len  = kl;
    next_cycle();
    in_valid = SP2V_LOW;
    key_len  = rand_key(); // Limit must come from the start edge
    exp_q    = exp_ctrl(kl, idx);
    while (out_valid != SP2V_HIGH && idx <= nr + 4) begin
      next_cycle();
      idx++;
      exp_q = exp_ctrl(kl, idx);
    end
    if (out_valid != SP2V_HIGH) begin
      err_cnt++;
      $display("Block with %0d rounds never raised out_valid_o", nr);
    end else if (idx != nr + 1) begin
      err_cnt++;
      $display("FAIL %0d ns: out_valid_o rose at cycle %0d, expected %0d", $time, idx, nr + 1);
    end
    repeat (stall) next_cycle();
    out_ready = SP2V_HIGH;
    next_cycle();
    out_ready = SP2V_LOW;
    exp_q     = exp_ctrl(kl, IdxIdle);
  endtask

  // Fault from idle, then the error state must hold against legal traffic
  task automatic fault_test(input bit bad_key);
    if (bad_key) begin
      in_valid = SP2V_HIGH;
      key_len  = key_len_e'(3'b011);
    end else begin
      in_valid = sp2v_e'(3'b000);
    end
    next_cycle();
    exp_q    = exp_ctrl(KEY_128, IdxError);
    in_valid = SP2V_LOW;
    key_len  = KEY_128;
    repeat (4) next_cycle();
    in_valid  = SP2V_HIGH;
    out_ready = SP2V_HIGH;
    next_cycle();
    in_valid  = SP2V_LOW;
    out_ready = SP2V_LOW;
    repeat (4) next_cycle();
    apply_reset();
    repeat (3) next_cycle();
  endtask

  // Watchdog
  initial begin
    #(WatchdogCyc * ClkPeriod);
    $display("Timeout: the run did not finish within %0d clock cycles", WatchdogCyc);
    $display("Errors found");
    $finish;
  end

  initial begin
    key_len_e kl_list [3];
    int       stall;
    void'($urandom(33));
    kl_list[0] = KEY_128;
    kl_list[1] = KEY_192;
    kl_list[2] = KEY_256;
    rst_ni     = 1'b0;
    in_valid   = SP2V_LOW;
    out_ready  = SP2V_LOW;
    key_len    = KEY_128;
    exp_q      = exp_ctrl(KEY_128, IdxIdle);

    apply_reset();
    repeat (3) next_cycle();
    end_test("reset state");

    foreach (kl_list[k]) begin
      run_block(kl_list[k], 0);
      end_test($sformatf("single block, %0d rounds", num_rounds(kl_list[k])));
    end

    stall = 1 + int'($urandom % 8);
    run_block(rand_key(), stall);
    end_test($sformatf("back-pressure, %0d stall cycles", stall));

    repeat (20) run_block(rand_key(), int'($urandom % 9));
    end_test("twenty back-to-back blocks");

    apply_reset();
    fault_test(1'b0);
    end_test("illegal in_valid code");
    apply_reset();
    fault_test(1'b1);
    end_test("illegal key length");

    $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+logic
logic/aes_ctrl_pkg.sv
logic/aes_sparse_chk.sv
logic/aes_round_fsm.sv
logic/aes_rail_combine.sv
logic/aes_ctrl_out.sv
logic/aes_round_ctrl.sv
sim/tb_aes_round_ctrl.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the result from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_aes_round_ctrl -f list.f \
  && ./obj_dir/Vtb_aes_round_ctrl > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Errors found" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "No errors" sim.log || { echo "No result in log"; exit 1; }
echo "Simulation PASSED"
